// ==== logic/lane_pkg.sv ====
// Shared definitions for the vector lane
// Widths, register index and word types
// Opcode and element-width enums
// Instruction, decoded uop and writeback structs

`default_nettype none

package lane_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Defaults for the top-level NrWords and WordWidth
  localparam int unsigned NR_VREGS   = 16;
  localparam int unsigned WORD_WIDTH = 32;

  // Derived widths
  localparam int unsigned VREG_AW  = $clog2(NR_VREGS);
  localparam int unsigned NR_BYTES = WORD_WIDTH / 8;

  typedef logic [VREG_AW-1:0]    vreg_addr_t;
  typedef logic [WORD_WIDTH-1:0] vec_word_t;
  typedef logic [NR_BYTES-1:0]   byte_en_t;

  ////////////////////
  // Encodings
  ////////////////////

  // All eight codes in use, MIN/MAX are signed
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_MIN  = 3'd5,
    OP_MAX  = 3'd6,
    OP_MOVI = 3'd7
  } lane_op_e;

  // Element width, code 3 is reserved
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2
  } elem_width_e;

  ////////////////////
  // Structs
  ////////////////////

  // Instruction word as it enters the lane
  typedef struct packed {
    lane_op_e    op;
    elem_width_e ew;
    vreg_addr_t  vd;
    vreg_addr_t  vs1;
    vreg_addr_t  vs2;
    byte_en_t    be;
    vec_word_t   imm;
  } lane_instr_t;

  // Decoded operation, sequencer to ALU
  typedef struct packed {
    lane_op_e    op;
    elem_width_e ew;
    vreg_addr_t  vd;
    byte_en_t    be;
    vec_word_t   imm;
  } lane_uop_t;

  // Register file write request
  typedef struct packed {
    logic       we;
    vreg_addr_t waddr;
    vec_word_t  wdata;
    byte_en_t   wbe;
  } vrf_wb_t;

endpackage

`default_nettype wire

// ==== logic/lane_sequencer.sv ====
// Instruction decode and operand-read stage
// Registers the uop and the two source addresses
// MOVI reads its own destination instead of stray sources

`timescale 1ns/1ps
`default_nettype none

module lane_sequencer (
  input  logic                             clk,
  input  logic                             rst_n_i,
  // Instruction strobe
  input  logic                             instr_valid_i,
  input  lane_pkg::lane_instr_t            instr_i,
  // Operand-read stage
  output logic                             uop_valid_o,
  output lane_pkg::lane_uop_t              uop_o,
  output lane_pkg::vreg_addr_t [1:0]       rs_addr_o
);

  ////////////////////
  // Signals
  ////////////////////

  // Next-state decode
  lane_pkg::lane_uop_t             uop_d;
  lane_pkg::vreg_addr_t [1:0]      rs_d;

  // Stage registers
  logic                            uop_valid_q;
  lane_pkg::lane_uop_t             uop_q;
  lane_pkg::vreg_addr_t [1:0]      rs_q;

  ////////////////////
  // Decode
  ////////////////////

  always_comb begin
    // Fields pass straight into the uop
    uop_d.op  = instr_i.op;
    uop_d.ew  = instr_i.ew;
    uop_d.vd  = instr_i.vd;
    uop_d.be  = instr_i.be;
    uop_d.imm = instr_i.imm;

    // Source selection per opcode
    unique case (instr_i.op)
      lane_pkg::OP_MOVI: begin
        // No operands needed, park both ports on vd
        rs_d[0] = instr_i.vd;
        rs_d[1] = instr_i.vd;
      end
      default: begin
        rs_d[0] = instr_i.vs1;
        rs_d[1] = instr_i.vs2;
      end
    endcase
  end

  ////////////////////
  // Stage registers
  ////////////////////

  // Valid bit is the only control state
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      uop_valid_q <= 1'b0;
    end else begin
      uop_valid_q <= instr_valid_i;
    end
  end

  // Payload loads on the strobe only
  always_ff @(posedge clk) begin
    if (instr_valid_i) begin
      uop_q <= uop_d;
      rs_q  <= rs_d;
    end
  end

  assign uop_valid_o = uop_valid_q;
  assign uop_o       = uop_q;

  // Read ports 0 and 1 are combinational, so
  // operands land in this same stage
  assign rs_addr_o   = rs_q;

  ////////////////////
  // Checks
  ////////////////////

  // Strobed instruction must carry a known opcode and width
  a_legal_instr : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    instr_valid_i |-> !$isunknown(instr_i.op) &&
                      (instr_i.ew inside {lane_pkg::EW8, lane_pkg::EW16, lane_pkg::EW32})
  ) else $error("lane_sequencer: illegal instruction op=%0d ew=%0d",
                instr_i.op, instr_i.ew);

endmodule

`default_nettype wire

// ==== logic/simd_alu.sv ====
// Element-wise SIMD ALU at 8, 16 or 32-bit elements
// Segmented byte adder, carry broken at element edges
// Signed MIN/MAX from the subtract path
// Writeback register toward the register file

`timescale 1ns/1ps
`default_nettype none

module simd_alu (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                uop_valid_i,
  input  lane_pkg::lane_uop_t uop_i,
  input  lane_pkg::vec_word_t opa_i,
  input  lane_pkg::vec_word_t opb_i,
  output lane_pkg::vrf_wb_t   wb_o
);

  localparam int unsigned NB = lane_pkg::NR_BYTES;

  // Subtract path for SUB, MIN and MAX
  logic                sub;
  // Element boundaries and per-byte carries
  logic [NB-1:0]       elem_start;
  logic [NB-1:0]       cin;
  logic [NB-1:0]       cout;
  // Signed a < b at each element top byte, then per byte
  logic [NB-1:0]       lt_top;
  logic [NB-1:0]       lt_byte;
  lane_pkg::vec_word_t result;
  // Writeback registers
  logic                we_q;
  lane_pkg::vreg_addr_t waddr_q;
  lane_pkg::vec_word_t wdata_q;
  lane_pkg::byte_en_t  wbe_q;

  assign sub = (uop_i.op != lane_pkg::OP_ADD);

  ////////////////////
  // Byte slices
  ////////////////////

  for (genvar b = 0; b < NB; b++) begin : gen_byte
    logic [7:0] a_byte;
    logic [7:0] b_byte;
    logic [8:0] sum;

    assign a_byte = opa_i[b*8 +: 8];
    assign b_byte = opb_i[b*8 +: 8];

    // Element starts at this byte for the current width
    assign elem_start[b] = (uop_i.ew == lane_pkg::EW8) ||
                           ((uop_i.ew == lane_pkg::EW16) && (b % 2 == 0)) ||
                           (b % 4 == 0);

    // Fresh carry-in at a boundary, else ripple
    if (b == 0) begin : gen_cin0
      assign cin[b] = sub;
    end else begin : gen_cinn
      assign cin[b] = elem_start[b] ? sub : cout[b-1];
    end

    assign sum     = {1'b0, a_byte} + {1'b0, b_byte ^ {8{sub}}} + {8'd0, cin[b]};
    assign cout[b] = sum[8];

    // Sign of difference corrected by overflow
    assign lt_top[b] = sum[7] ^ ((a_byte[7] ^ b_byte[7]) & (a_byte[7] ^ sum[7]));

    // Compare result lives at the element's top byte
    always_comb begin
      unique case (uop_i.ew)
        lane_pkg::EW8:  lt_byte[b] = lt_top[b];
        lane_pkg::EW16: lt_byte[b] = lt_top[(b / 2) * 2 + 1];
        default:        lt_byte[b] = lt_top[NB-1];
      endcase
    end

    // Opcode select per byte
    always_comb begin
      unique case (uop_i.op)
        lane_pkg::OP_ADD,
        lane_pkg::OP_SUB:  result[b*8 +: 8] = sum[7:0];
        lane_pkg::OP_AND:  result[b*8 +: 8] = a_byte & b_byte;
        lane_pkg::OP_OR:   result[b*8 +: 8] = a_byte | b_byte;
        lane_pkg::OP_XOR:  result[b*8 +: 8] = a_byte ^ b_byte;
        lane_pkg::OP_MIN:  result[b*8 +: 8] = lt_byte[b] ? a_byte : b_byte;
        lane_pkg::OP_MAX:  result[b*8 +: 8] = lt_byte[b] ? b_byte : a_byte;
        default:           result[b*8 +: 8] = uop_i.imm[b*8 +: 8];
      endcase
    end
  end

  ////////////////////
  // Writeback
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      we_q <= 1'b0;
    end else begin
      we_q <= uop_valid_i;
    end
  end

  // Payload held between uops
  always_ff @(posedge clk) begin
    if (uop_valid_i) begin
      waddr_q <= uop_i.vd;
      wdata_q <= result;
      wbe_q   <= uop_i.be;
    end
  end

  assign wb_o = '{we: we_q, waddr: waddr_q, wdata: wdata_q, wbe: wbe_q};

  // Sequencer should never issue a uop that writes nothing
  a_be_nonzero : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    uop_valid_i |-> (uop_i.be != '0)
  ) else $error("simd_alu: valid uop with empty byte mask");

endmodule

`default_nettype wire

// ==== logic/vector_lane.sv ====
// Top level of one vector lane
// Sequencer, register file and SIMD ALU
// Debug read on the third register file port

`timescale 1ns/1ps
`default_nettype none

module vector_lane #(
  parameter int unsigned NrWords   = lane_pkg::NR_VREGS,
  parameter int unsigned WordWidth = lane_pkg::WORD_WIDTH
) (
  input  logic                  clk,
  input  logic                  rst_n_i,
  // Instruction strobe
  input  logic                  instr_valid_i,
  input  lane_pkg::lane_instr_t instr_i,
  // Debug read
  input  lane_pkg::vreg_addr_t  dbg_raddr_i,
  output lane_pkg::vec_word_t   dbg_rdata_o,
  // Write-back observation
  output lane_pkg::vrf_wb_t     wb_o
);

  // Sequencer to ALU
  logic                           uop_valid;
  lane_pkg::lane_uop_t            uop;
  lane_pkg::vreg_addr_t [1:0]     rs_addr;

  // Register file ports, 0 and 1 operands, 2 debug
  lane_pkg::vreg_addr_t [2:0]     raddr;
  lane_pkg::vec_word_t  [2:0]     rdata;

  // ALU write request
  lane_pkg::vrf_wb_t              wb;

  assign raddr       = {dbg_raddr_i, rs_addr[1], rs_addr[0]};
  assign dbg_rdata_o = rdata[2];
  assign wb_o        = wb;

  lane_sequencer i_sequencer (
    .clk          (clk          ),
    .rst_n_i      (rst_n_i      ),
    .instr_valid_i(instr_valid_i),
    .instr_i      (instr_i      ),
    .uop_valid_o  (uop_valid    ),
    .uop_o        (uop          ),
    .rs_addr_o    (rs_addr      )
  );

  vregfile #(
    .NrReadPorts(3        ),
    .NrWords    (NrWords  ),
    .WordWidth  (WordWidth)
  ) i_vregfile (
    .clk    (clk    ),
    .rst_n_i(rst_n_i),
    .wr_i   (wb     ),
    .raddr_i(raddr  ),
    .rdata_o(rdata  )
  );

  simd_alu i_alu (
    .clk        (clk      ),
    .rst_n_i    (rst_n_i  ),
    .uop_valid_i(uop_valid),
    .uop_i      (uop      ),
    .opa_i      (rdata[0] ),
    .opb_i      (rdata[1] ),
    .wb_o       (wb       )
  );

endmodule

`default_nettype wire

// ==== logic/vregfile.sv ====
// Vector register file built from flip-flops
// One byte-masked write port
// NrReadPorts combinational read ports through mux trees

`timescale 1ns/1ps
`default_nettype none

module vregfile #(
  parameter int unsigned NrReadPorts = 3,
  parameter int unsigned NrWords     = lane_pkg::NR_VREGS,
  parameter int unsigned WordWidth   = lane_pkg::WORD_WIDTH
) (
  input  logic                                         clk,
  input  logic                                         rst_n_i,
  // Write port
  input  lane_pkg::vrf_wb_t                            wr_i,
  // Read ports
  input  lane_pkg::vreg_addr_t [NrReadPorts-1:0]       raddr_i,
  output lane_pkg::vec_word_t  [NrReadPorts-1:0]       rdata_o
);

  localparam int unsigned NrBytes = WordWidth / 8;

  ////////////////////
  // Signals
  ////////////////////

  // Storage, word by byte
  logic [NrWords-1:0][NrBytes-1:0][7:0] mem;

  // One-hot row select and byte column select
  logic [NrWords-1:0] row_sel;
  logic [NrBytes-1:0] col_sel;

  ////////////////////
  // Write decode
  ////////////////////

  // Row decoder, gated by the write flag
  for (genvar row = 0; row < NrWords; row++) begin : gen_row_dec
    assign row_sel[row] = wr_i.we && (wr_i.waddr == lane_pkg::vreg_addr_t'(row));
  end

  // Column decoder straight from the byte enables
  assign col_sel = wr_i.wbe;

  ////////////////////
  // Storage
  ////////////////////

  // Only bytes hit by both row and column change
  // An all-zero wbe leaves the word untouched
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      mem <= '0;
    end else begin
      for (int w = 0; w < NrWords; w++) begin
        for (int b = 0; b < NrBytes; b++) begin
          if (row_sel[w] && col_sel[b]) begin
            mem[w][b] <= wr_i.wdata[b*8 +: 8];
          end
        end
      end
    end
  end

  ////////////////////
  // Read ports
  ////////////////////

  // Dedicated mux tree per port
  for (genvar port = 0; port < NrReadPorts; port++) begin : gen_read
    vrf_read_tree #(
      .NrWords  (NrWords  ),
      .WordWidth(WordWidth)
    ) i_read_tree (
      .words_i(mem          ),
      .sel_i  (raddr_i[port]),
      .word_o (rdata_o[port])
    );
  end

  ////////////////////
  // Checks
  ////////////////////

  // ALU must never target a register beyond the file
  a_waddr_in_range : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    wr_i.we |-> (int'(wr_i.waddr) < NrWords)
  ) else $error("vregfile: write to register %0d out of range", wr_i.waddr);

endmodule

`default_nettype wire

// ==== logic/vrf_read_tree.sv ====
// Binary read multiplexer for the register file
// One 2:1 mux level per select bit, LSB first

`timescale 1ns/1ps
`default_nettype none

module vrf_read_tree #(
  parameter int unsigned NrWords   = lane_pkg::NR_VREGS,
  parameter int unsigned WordWidth = lane_pkg::WORD_WIDTH
) (
  input  logic [NrWords-1:0][WordWidth-1:0] words_i,
  input  lane_pkg::vreg_addr_t              sel_i,
  output lane_pkg::vec_word_t               word_o
);

  // Tree depth, at least one level
  localparam int unsigned Levels    = (NrWords > 1) ? $clog2(NrWords) : 1;
  localparam int unsigned NumLeaves = 2 ** Levels;

  // Node storage per level, level 0 holds the leaves
  logic [Levels:0][NumLeaves-1:0][WordWidth-1:0] node;

  // Leaves, padded with zero up to a power of two
  for (genvar i = 0; i < NumLeaves; i++) begin : gen_leaf
    if (i < NrWords) begin : gen_word
      assign node[0][i] = words_i[i];
    end else begin : gen_pad
      assign node[0][i] = '0;
    end
  end

  // Level l halves the candidates using select bit l
  for (genvar l = 0; l < Levels; l++) begin : gen_level
    for (genvar i = 0; i < NumLeaves; i++) begin : gen_node
      if (i < (NumLeaves >> (l + 1))) begin : gen_mux
        assign node[l+1][i] = sel_i[l] ? node[l][2*i+1] : node[l][2*i];
      end else begin : gen_unused
        // Slot above the live nodes of this level
        assign node[l+1][i] = '0;
      end
    end
  end

  // Root
  assign word_o = node[Levels][0];

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the vector lane testbench with Verilator, run it, and scan the log

cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_vector_lane \
  -f sources.f -Mdir obj_dir -o sim_vector_lane > build.log 2>&1 &&
./obj_dir/sim_vector_lane > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "Build or run error"; exit 1; }

cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0

// ==== sources.f ====
logic/lane_pkg.sv
logic/vrf_read_tree.sv
logic/vregfile.sv
logic/lane_sequencer.sv
logic/simd_alu.sv
logic/vector_lane.sv
verif/lane_checker.sv
verif/tb_vector_lane.sv

// ==== verif/lane_checker.sv ====
// Checker for the vector lane testbench
// Queue of expected write-backs with due cycles
// Monitor of wb_o on the falling edge
// Debug read compare and error counters

`timescale 1ns/1ps
`default_nettype none

module lane_checker (
  input logic                clk,
  input logic                rst_n_i,
  input lane_pkg::vrf_wb_t   wb_i,
  input lane_pkg::vec_word_t dbg_rdata_i
);

  int unsigned err_count   = 0;
  int unsigned check_count = 0;
  // Rising edges since start
  int unsigned cycle       = 0;

  // Pending write-backs and the cycle each one is due
  lane_pkg::vrf_wb_t exp_q [$];
  int unsigned       due_q [$];
  lane_pkg::vrf_wb_t exp_cur;
  int unsigned       due_cur;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic compare_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // Called on the falling edge that drives the strobe
  task automatic expect_wb(input lane_pkg::vrf_wb_t exp, input int unsigned latency);
    exp_q.push_back(exp);
    due_q.push_back(cycle + latency);
  endtask

  // Bounded wait until every pending write-back has been seen
  task automatic wait_idle(input int unsigned max_cycles);
    int unsigned n;
    n = 0;
    while (exp_q.size() != 0 && n < max_cycles) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      err_count++;
      $display("Timeout at %0t: %0d write-backs still pending after %0d cycles",
               $time, exp_q.size(), max_cycles);
      exp_q.delete();
      due_q.delete();
    end
  endtask

  task automatic check_dbg(input lane_pkg::vreg_addr_t addr, input lane_pkg::vec_word_t exp);
    compare_field($sformatf("dbg_rdata_o (v%0d)", addr), exp, dbg_rdata_i);
  endtask

  // Write-back strobe cleared by reset
  task automatic check_we_low();
    compare_field("wb_o.we", 32'd0, 32'(wb_i.we));
  endtask

  ////////////////////
  // Write-back monitor
  ////////////////////

  // Sample wb_o half a cycle after it settles
  always @(negedge clk) begin
    if (rst_n_i) begin
      if (wb_i.we === 1'b1 && exp_q.size() == 0) begin
        // Pulse nobody asked for
        compare_field("wb_o.we", 32'd0, 32'd1);
      end else if (wb_i.we === 1'b1) begin
        exp_cur = exp_q.pop_front();
        due_cur = due_q.pop_front();
        compare_field("wb_o.waddr", 32'(exp_cur.waddr), 32'(wb_i.waddr));
        compare_field("wb_o.wdata", exp_cur.wdata, wb_i.wdata);
        compare_field("wb_o.wbe", 32'(exp_cur.wbe), 32'(wb_i.wbe));
        if (cycle != due_cur) begin
          err_count++;
          $display("Write-back to v%0d came in cycle %0d instead of cycle %0d",
                   exp_cur.waddr, cycle, due_cur);
        end
      end else if (wb_i.we !== 1'b0) begin
        compare_field("wb_o.we", 32'd0, 32'(wb_i.we));
      end else if (due_q.size() != 0 && cycle >= due_q[0]) begin
        exp_cur = exp_q.pop_front();
        due_cur = due_q.pop_front();
        err_count++;
        $display("No write-back to v%0d by cycle %0d", exp_cur.waddr, due_cur);
      end
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_vector_lane.sv ====
// Testbench for the vector lane
// Clock, reset, stimulus table with model results
// Drive loop on the falling edge, checks in lane_checker

`timescale 1ns/1ps
`default_nettype none

module tb_vector_lane;

  localparam int unsigned NrWords    = lane_pkg::NR_VREGS;
  localparam int unsigned WordWidth  = lane_pkg::WORD_WIDTH;
  localparam int unsigned ClkHalf    = 20;
  localparam int unsigned MaxEntries = 64;
  // Strobe edge to write-back pulse
  localparam int unsigned WbLatency  = 2;

  // One table row with stimulus, expected write word and register image
  typedef struct packed {
    lane_pkg::lane_instr_t instr;
    logic                  chain;
    lane_pkg::vec_word_t   exp_wdata;
    lane_pkg::vec_word_t   exp_reg;
  } entry_t;

  logic                  clk;
  logic                  rst_n_i;
  logic                  instr_valid_i;
  lane_pkg::lane_instr_t instr_i;
  lane_pkg::vreg_addr_t  dbg_raddr_i;
  lane_pkg::vec_word_t   dbg_rdata_o;
  lane_pkg::vrf_wb_t     wb_o;

  int                    seed;
  int                    n_entries;
  entry_t                tbl [MaxEntries];
  lane_pkg::vec_word_t   model_rf [NrWords];

  vector_lane #(
    .NrWords  (NrWords  ),
    .WordWidth(WordWidth)
  ) DUT (
    .clk          (clk          ),
    .rst_n_i      (rst_n_i      ),
    .instr_valid_i(instr_valid_i),
    .instr_i      (instr_i      ),
    .dbg_raddr_i  (dbg_raddr_i  ),
    .dbg_rdata_o  (dbg_rdata_o  ),
    .wb_o         (wb_o         )
  );

  lane_checker i_checker (
    .clk        (clk        ),
    .rst_n_i    (rst_n_i    ),
    .wb_i       (wb_o       ),
    .dbg_rdata_i(dbg_rdata_o)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkHalf) clk = ~clk;
  end

  ////////////////////
  // Reference model
  ////////////////////

  // Element-wise model with signed MIN/MAX and no carry between elements
  function automatic lane_pkg::vec_word_t model_result(
    input lane_pkg::lane_op_e op, input lane_pkg::elem_width_e ew,
    input lane_pkg::vec_word_t a, input lane_pkg::vec_word_t b, input lane_pkg::vec_word_t imm);
    int                 esz;
    int                 shift;
    logic [31:0]        mask;
    logic [31:0]        ea;
    logic [31:0]        eb;
    logic [31:0]        r;
    logic [31:0]        res;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    case (ew)
      lane_pkg::EW8:  esz = 8;
      lane_pkg::EW16: esz = 16;
      default:        esz = 32;
    endcase
    mask = (esz == 32) ? 32'hffff_ffff : ((32'd1 << esz) - 32'd1);
    res  = '0;
    for (int e = 0; e < 32 / esz; e++) begin
      shift = e * esz;
      ea    = (a >> shift) & mask;
      eb    = (b >> shift) & mask;
      // Sign-extend the element to 32 bits
      sa    = $signed(ea << (32 - esz)) >>> (32 - esz);
      sb    = $signed(eb << (32 - esz)) >>> (32 - esz);
      case (op)
        lane_pkg::OP_ADD: r = ea + eb;
        lane_pkg::OP_SUB: r = ea - eb;
        lane_pkg::OP_AND: r = ea & eb;
        lane_pkg::OP_OR:  r = ea | eb;
        lane_pkg::OP_XOR: r = ea ^ eb;
        lane_pkg::OP_MIN: r = (sa < sb) ? ea : eb;
        lane_pkg::OP_MAX: r = (sa < sb) ? eb : ea;
        default:          r = '0;
      endcase
      res = res | ((r & mask) << shift);
    end
    if (op == lane_pkg::OP_MOVI) begin
      res = imm;
    end
    return res;
  endfunction

  // Only enabled bytes take the new value
  function automatic lane_pkg::vec_word_t merge_bytes(input lane_pkg::vec_word_t old_w,
    input lane_pkg::vec_word_t new_w, input lane_pkg::byte_en_t be);
    lane_pkg::vec_word_t res;
    res = old_w;
    for (int b = 0; b < lane_pkg::NR_BYTES; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  ////////////////////
  // Stimulus table
  ////////////////////

  task automatic add_entry(input lane_pkg::lane_op_e op, input lane_pkg::elem_width_e ew,
    input lane_pkg::vreg_addr_t vd, input lane_pkg::vreg_addr_t vs1,
    input lane_pkg::vreg_addr_t vs2, input lane_pkg::byte_en_t be,
    input lane_pkg::vec_word_t imm, input logic chain);
    entry_t e;
    e           = '0;
    e.instr.op  = op;
    e.instr.ew  = ew;
    e.instr.vd  = vd;
    e.instr.vs1 = vs1;
    e.instr.vs2 = vs2;
    e.instr.be  = be;
    e.instr.imm = imm;
    e.chain     = chain;
    tbl[n_entries] = e;
    n_entries++;
  endtask

  task automatic build_table();
    int draw;
    // Full-mask loads of every register
    for (int r = 0; r < NrWords; r++) begin
      draw = $random(seed);
      add_entry(lane_pkg::OP_MOVI, lane_pkg::EW32, lane_pkg::vreg_addr_t'(r), '0, '0,
                4'hf, draw, 1'b0);
    end
    // Edge values for wrap-around and signed compares
    add_entry(lane_pkg::OP_MOVI, lane_pkg::EW32, 4'd14, '0, '0, 4'hf, 32'h80ff_7fff, 1'b0);
    add_entry(lane_pkg::OP_MOVI, lane_pkg::EW32, 4'd15, '0, '0, 4'hf, 32'h7f01_8001, 1'b0);
    // Partial masks
    add_entry(lane_pkg::OP_MOVI, lane_pkg::EW32, 4'd3, '0, '0, 4'b0101, $random(seed), 1'b0);
    add_entry(lane_pkg::OP_MOVI, lane_pkg::EW32, 4'd5, '0, '0, 4'b1000, $random(seed), 1'b0);
    add_entry(lane_pkg::OP_MOVI, lane_pkg::EW32, 4'd7, '0, '0, 4'b0110, $random(seed), 1'b0);
    // Every ALU op at every width on random sources
    for (int k = 0; k < 7; k++) begin
      for (int w = 0; w < 3; w++) begin
        draw = $random(seed);
        add_entry(lane_pkg::lane_op_e'(k[2:0]), lane_pkg::elem_width_e'(w[1:0]),
                  lane_pkg::vreg_addr_t'(8 + (3 * k + w) % 6), draw[3:0], draw[7:4],
                  4'hf, '0, 1'b0);
      end
    end
    add_entry(lane_pkg::OP_ADD, lane_pkg::EW8, 4'd12, 4'd14, 4'd15, 4'b1010, '0, 1'b0);
    // Back-to-back group whose sources it never writes
    add_entry(lane_pkg::OP_ADD, lane_pkg::EW16, 4'd1, 4'd14, 4'd15, 4'hf, '0, 1'b1);
    add_entry(lane_pkg::OP_SUB, lane_pkg::EW8, 4'd2, 4'd14, 4'd15, 4'hf, '0, 1'b1);
    add_entry(lane_pkg::OP_MAX, lane_pkg::EW32, 4'd4, 4'd15, 4'd14, 4'hf, '0, 1'b1);
    add_entry(lane_pkg::OP_MIN, lane_pkg::EW8, 4'd6, 4'd14, 4'd15, 4'hf, '0, 1'b0);
  endtask

  // Model run over the table from the reset image
  task automatic compute_expected();
    lane_pkg::lane_instr_t in;
    for (int r = 0; r < NrWords; r++) begin
      model_rf[r] = '0;
    end
    for (int i = 0; i < n_entries; i++) begin
      in                = tbl[i].instr;
      tbl[i].exp_wdata  = model_result(in.op, in.ew, model_rf[in.vs1], model_rf[in.vs2], in.imm);
      model_rf[in.vd]   = merge_bytes(model_rf[in.vd], tbl[i].exp_wdata, in.be);
      tbl[i].exp_reg    = model_rf[in.vd];
    end
  endtask

  ////////////////////
  // Drive
  ////////////////////

  task automatic read_check(input lane_pkg::vreg_addr_t addr, input lane_pkg::vec_word_t exp);
    @(negedge clk);
    dbg_raddr_i = addr;
    #(ClkHalf / 2);
    i_checker.check_dbg(addr, exp);
  endtask

  // Chained rows leave the strobe high for the next row
  task automatic issue_entry(input int idx);
    lane_pkg::vrf_wb_t exp_wb;
    exp_wb.we    = 1'b1;
    exp_wb.waddr = tbl[idx].instr.vd;
    exp_wb.wdata = tbl[idx].exp_wdata;
    exp_wb.wbe   = tbl[idx].instr.be;
    @(negedge clk);
    instr_valid_i = 1'b1;
    instr_i       = tbl[idx].instr;
    i_checker.expect_wb(exp_wb, WbLatency);
    if (!tbl[idx].chain) begin
      @(negedge clk);
      instr_valid_i = 1'b0;
      i_checker.wait_idle(8);
      read_check(tbl[idx].instr.vd, tbl[idx].exp_reg);
    end
  endtask

  // Two-cycle reset over a loaded file with a uop in flight
  task automatic apply_midrun_reset();
    @(negedge clk);
    instr_valid_i = 1'b1;
    instr_i       = tbl[0].instr;
    @(negedge clk);
    instr_valid_i = 1'b0;
    rst_n_i       = 1'b0;
    // First reset edge drops the pending write-back
    @(negedge clk);
    i_checker.check_we_low();
    @(negedge clk);
    rst_n_i = 1'b1;
    for (int r = 0; r < NrWords; r++) begin
      read_check(lane_pkg::vreg_addr_t'(r), '0);
    end
  endtask

  initial begin
    seed          = 66;
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    dbg_raddr_i   = '0;
    n_entries     = 0;
    build_table();
    compute_expected();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    // Every register reads zero after reset
    for (int r = 0; r < NrWords; r++) begin
      read_check(lane_pkg::vreg_addr_t'(r), '0);
    end
    for (int i = 0; i < n_entries; i++) begin
      issue_entry(i);
    end
    // Final image of the whole file
    for (int r = 0; r < NrWords; r++) begin
      read_check(lane_pkg::vreg_addr_t'(r), model_rf[r]);
    end
    apply_midrun_reset();
    @(negedge clk);
    $display("Checks: %0d, errors: %0d", i_checker.check_count, i_checker.err_count);
    if (i_checker.err_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
